// File: Bender.yml
package:
  name: ahb_subordinate

sources:
  - src/ahb_sub_pkg.sv
  - src/ahb_dphase_if.sv
  - src/ahb_dphase_capture.sv
  - src/ahb_sub_ctrl.sv
  - src/ahb_bus_request.sv
  - src/ahb_subordinate.sv
  - target: simulation
    files:
      - dv/ahb_sub_checker.sv
      - dv/tb_ahb_subordinate.sv

// File: dv/ahb_sub_checker.sv
// checker for the ahb subordinate
// tracks each accepted transfer and compares the DUT ports every rising edge

`timescale 1ns/1ps

module ahb_sub_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        hsel,
    input  logic [31:0] haddr,
    input  logic [1:0]  htrans,
    input  logic        hwrite,
    input  logic [2:0]  hsize,
    input  logic [2:0]  hburst,
    input  logic [31:0] hwdata,
    input  logic [3:0]  hwstrb,
    input  logic        hreadyout,
    input  logic        hresp,
    input  logic [31:0] hrdata,
    input  logic [31:0] bus_rdata,
    input  logic        bus_error,
    input  logic        bus_request_stall,
    input  logic [31:0] bus_addr,
    input  logic [31:0] bus_wdata,
    input  logic [3:0]  bus_strobe,
    input  logic        bus_wen,
    input  logic        bus_ren,
    input  logic        bus_is_burst,
    input  logic [1:0]  bus_burst_type,
    input  logic [7:0]  bus_burst_length,
    output int          error_count,
    output int          check_count
);
    import ahb_sub_pkg::*;

    typedef struct packed {
        logic ready;
        logic resp;
        logic wen;
        logic ren;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strobe;
        logic is_burst;
        logic [1:0] btype;
        logic [BLEN_W-1:0] blen;
    } exp_t;

    // 0 no transfer, 1 data phase, 2 second error cycle
    int phase;
    logic prev_ready;
    logic seen_edge;
    logic [ADDR_W-1:0] t_addr;
    logic t_write;
    logic [1:0] t_trans;
    logic [2:0] t_burst;
    logic [2:0] t_size;

    initial begin
        error_count = 0;
        check_count = 0;
        phase = 0;
        prev_ready = 1'b0;
        seen_edge = 1'b0;
    end

    // expected port values for one cycle
    function automatic exp_t expected_outputs(int ph, logic [ADDR_W-1:0] a, logic wr,
                                              logic [1:0] tr, logic [2:0] bu,
                                              logic [2:0] sz, logic prdy, logic stall,
                                              logic berr, logic [DATA_W-1:0] wd,
                                              logic [STRB_W-1:0] st);
        exp_t e;
        logic aerr;
        logic busy;
        int shift;
        e = '0;
        e.ready = 1'b1;
        if (ph == 2) begin
            e.resp = 1'b1;
            return e;
        end
        if (ph == 0) begin
            return e;
        end
        aerr = (a < BASE_ADDR) || (a >= TOP_ADDR) || (a % WORD_BYTES != 0);
        busy = (tr == HTRANS_BUSY);
        // address error counts only after a completed beat
        if ((aerr && prdy) || (berr && !busy)) begin
            e.ready = 1'b0;
            e.resp = 1'b1;
        end else if (!busy && stall) begin
            e.ready = 1'b0;
        end
        if (!busy && !aerr) begin
            e.addr = a;
            e.wdata = wd;
            e.strobe = st;
            e.wen = wr;
            e.ren = !wr;
        end
        if (!aerr && bu != 3'd0) begin
            e.is_burst = 1'b1;
            e.btype = bu[0] ? BURST_TYPE_INCR : BURST_TYPE_WRAP;
            // size code shifted by len_code plus one
            shift = int'(bu[2:1]) + 1;
            if (bu[2:1] != 2'd0) begin
                e.blen = BLEN_W'(int'(sz) << shift);
            end
        end
        return e;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
        check_count++;
        if (exp !== got) begin
            error_count++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic compare_all(input exp_t e, input logic [DATA_W-1:0] rd);
        check_val("hreadyout", e.ready, hreadyout);
        check_val("hresp", e.resp, hresp);
        check_val("hrdata", rd, hrdata);
        check_val("bus_wen", e.wen, bus_wen);
        check_val("bus_ren", e.ren, bus_ren);
        check_val("bus_addr", e.addr, bus_addr);
        check_val("bus_wdata", e.wdata, bus_wdata);
        check_val("bus_strobe", e.strobe, bus_strobe);
        check_val("bus_is_burst", e.is_burst, bus_is_burst);
        check_val("bus_burst_type", e.btype, bus_burst_type);
        check_val("bus_burst_length", e.blen, bus_burst_length);
    endtask

    always @(posedge clk) begin
        exp_t e;
        logic accept;
        int old_phase;
        if (!rst_n) begin
            // outputs settle after the first reset edge
            if (seen_edge) begin
                compare_all(expected_outputs(0, '0, 0, 0, 0, 0, 0, 0, 0, '0, '0), '0);
            end
            seen_edge = 1'b1;
            phase = 0;
            prev_ready = 1'b0;
        end else begin
            e = expected_outputs(phase, t_addr, t_write, t_trans, t_burst, t_size,
                                 prev_ready, bus_request_stall, bus_error, hwdata, hwstrb);
            compare_all(e, (phase == 0) ? '0 : bus_rdata);
            old_phase = phase;
            accept = hsel && (htrans != HTRANS_IDLE) && e.ready && (old_phase != 2);
            if (old_phase == 1 && !e.ready) begin
                phase = e.resp ? 2 : 1;
            end else begin
                phase = 0;
            end
            if (accept && phase == 0) begin
                t_addr = haddr;
                t_write = hwrite;
                t_trans = htrans;
                t_burst = hburst;
                t_size = hsize;
                phase = 1;
            end
            prev_ready = e.ready;
        end
    end

endmodule

// File: dv/tb_ahb_subordinate.sv
// testbench top for the ahb subordinate
// ahb manager stimulus, downstream bus model and the test sequence

`timescale 1ns/1ps

module tb_ahb_subordinate;
    import ahb_sub_pkg::*;

    localparam int MAX_WAIT = 20;

    logic clk = 1'b0;
    logic rst_n;
    logic hsel;
    logic [ADDR_W-1:0] haddr;
    logic [1:0] htrans;
    logic hwrite;
    logic [2:0] hsize;
    logic [2:0] hburst;
    logic [DATA_W-1:0] hwdata;
    logic [STRB_W-1:0] hwstrb;
    logic hreadyout;
    logic hresp;
    logic [DATA_W-1:0] hrdata;
    logic [DATA_W-1:0] bus_rdata;
    logic bus_error;
    logic bus_request_stall;
    logic [ADDR_W-1:0] bus_addr;
    logic [DATA_W-1:0] bus_wdata;
    logic [STRB_W-1:0] bus_strobe;
    logic bus_wen;
    logic bus_ren;
    logic bus_is_burst;
    logic [1:0] bus_burst_type;
    logic [BLEN_W-1:0] bus_burst_length;
    int error_count;
    int check_count;
    int timeouts;
    int last_errors;
    // downstream read data per word of the window
    logic [DATA_W-1:0] model_mem [NWORDS];

    always #10 clk = ~clk;

    // read data is a fixed function of the request address
    assign bus_rdata = model_mem[bus_addr[3:2]];

    ahb_subordinate ahb_subordinate_i (
        .ahb_if(clk), .rst_n(rst_n), .hsel(hsel), .haddr(haddr), .htrans(htrans),
        .hwrite(hwrite), .hsize(hsize), .hburst(hburst), .hwdata(hwdata),
        .hwstrb(hwstrb), .hreadyout(hreadyout), .hresp(hresp), .hrdata(hrdata),
        .bus_rdata(bus_rdata), .bus_error(bus_error),
        .bus_request_stall(bus_request_stall), .bus_addr(bus_addr),
        .bus_wdata(bus_wdata), .bus_strobe(bus_strobe), .bus_wen(bus_wen),
        .bus_ren(bus_ren), .bus_is_burst(bus_is_burst),
        .bus_burst_type(bus_burst_type), .bus_burst_length(bus_burst_length)
    );

    ahb_sub_checker checker_i (
        .clk(clk), .rst_n(rst_n), .hsel(hsel), .haddr(haddr), .htrans(htrans),
        .hwrite(hwrite), .hsize(hsize), .hburst(hburst), .hwdata(hwdata),
        .hwstrb(hwstrb), .hreadyout(hreadyout), .hresp(hresp), .hrdata(hrdata),
        .bus_rdata(bus_rdata), .bus_error(bus_error),
        .bus_request_stall(bus_request_stall), .bus_addr(bus_addr),
        .bus_wdata(bus_wdata), .bus_strobe(bus_strobe), .bus_wen(bus_wen),
        .bus_ren(bus_ren), .bus_is_burst(bus_is_burst),
        .bus_burst_type(bus_burst_type), .bus_burst_length(bus_burst_length),
        .error_count(error_count), .check_count(check_count)
    );

    // runs the data phase until hreadyout, starting and ending on a falling edge
    task automatic data_phase_wait(input int stalls, input logic berr);
        int n;
        logic done;
        n = 0;
        done = 1'b0;
        while (!done && n < MAX_WAIT) begin
            bus_request_stall = (stalls > 0);
            bus_error = berr && (stalls == 0);
            @(posedge clk);
            if (hreadyout) begin
                done = 1'b1;
            end
            // error reported once, second error cycle follows
            if (bus_error) begin
                berr = 1'b0;
            end
            if (stalls > 0) begin
                stalls--;
            end
            n++;
            @(negedge clk);
        end
        bus_request_stall = 1'b0;
        bus_error = 1'b0;
        if (!done) begin
            timeouts++;
            $display("timeout at %0t: data phase never completed", $time);
        end
    endtask

    // one nonseq transfer followed by an idle address phase
    task automatic transfer(input logic [ADDR_W-1:0] addr, input logic wr,
                            input logic [2:0] burst, input logic [2:0] size,
                            input int stalls, input logic berr);
        @(negedge clk);
        hsel = 1'b1;
        haddr = addr;
        htrans = 2'b10;
        hwrite = wr;
        hburst = burst;
        hsize = size;
        @(negedge clk);
        hsel = 1'b0;
        htrans = HTRANS_IDLE;
        hwdata = $urandom;
        hwstrb = STRB_W'($urandom);
        data_phase_wait(stalls, berr);
    endtask

    function automatic logic [ADDR_W-1:0] rand_word_addr();
        return BASE_ADDR + ($urandom % NWORDS) * WORD_BYTES;
    endfunction

    task automatic end_test(input string name);
        $display("test %s: %0d errors", name, error_count - last_errors);
        last_errors = error_count;
    endtask

    initial begin
        void'($urandom(99181));
        timeouts = 0;
        last_errors = 0;
        rst_n = 1'b0;
        hsel = 1'b0;
        haddr = '0;
        htrans = HTRANS_IDLE;
        hwrite = 1'b0;
        hsize = 3'd0;
        hburst = 3'd0;
        hwdata = '0;
        hwstrb = '0;
        bus_error = 1'b0;
        bus_request_stall = 1'b0;
        for (int i = 0; i < NWORDS; i++) begin
            model_mem[i] = $urandom;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);
        end_test("reset");

        for (int i = 0; i < 8; i++) begin
            transfer(rand_word_addr(), 1'($urandom), 3'd0, 3'd2, 0, 1'b0);
        end
        end_test("single");

        for (int b = 1; b < 8; b++) begin
            for (int s = 0; s < 3; s++) begin
                transfer(rand_word_addr(), 1'($urandom), 3'(b), 3'(s), 0, 1'b0);
            end
        end
        end_test("burst_decode");

        for (int i = 0; i < 6; i++) begin
            transfer(rand_word_addr(), 1'($urandom), 3'd0, 3'd2, $urandom % 4, 1'b0);
        end
        transfer(rand_word_addr(), 1'b1, 3'd0, 3'd2, 3, 1'b0);
        end_test("stall");

        // incr4 beat followed by a busy beat
        @(negedge clk);
        hsel = 1'b1;
        haddr = rand_word_addr();
        htrans = 2'b10;
        hwrite = 1'b1;
        hburst = 3'd3;
        hsize = 3'd2;
        @(negedge clk);
        htrans = HTRANS_BUSY;
        hwdata = $urandom;
        data_phase_wait(0, 1'b0);
        hsel = 1'b0;
        htrans = HTRANS_IDLE;
        data_phase_wait(0, 1'b0);
        end_test("busy");

        transfer(TOP_ADDR, 1'b1, 3'd0, 3'd2, 0, 1'b0);
        transfer(BASE_ADDR - 4, 1'b0, 3'd0, 3'd2, 0, 1'b0);
        transfer(BASE_ADDR + 2, 1'b1, 3'd0, 3'd2, 0, 1'b0);
        transfer(rand_word_addr(), 1'b0, 3'd0, 3'd2, 0, 1'b1);
        transfer(rand_word_addr(), 1'b1, 3'd0, 3'd2, 1, 1'b1);
        end_test("error");

        repeat (2) @(negedge clk);
        $display("%0d checks, %0d errors, %0d timeouts", check_count, error_count, timeouts);
        if (error_count == 0 && timeouts == 0 && check_count > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
src/ahb_sub_pkg.sv
src/ahb_dphase_if.sv
src/ahb_dphase_capture.sv
src/ahb_sub_ctrl.sv
src/ahb_bus_request.sv
src/ahb_subordinate.sv
dv/ahb_sub_checker.sv
dv/tb_ahb_subordinate.sv

// File: src/ahb_bus_request.sv
// downstream request driver
// forwards address, live write data and strobe, decodes hburst/hsize

`timescale 1ns/1ps

module ahb_bus_request (
    ahb_dphase_if.user                  dp,
    input  logic                        req_en,
    input  logic                        burst_en,
    input  logic [ahb_sub_pkg::DATA_W-1:0] hwdata,
    input  logic [ahb_sub_pkg::STRB_W-1:0] hwstrb,
    output logic [ahb_sub_pkg::ADDR_W-1:0] bus_addr,
    output logic [ahb_sub_pkg::DATA_W-1:0] bus_wdata,
    output logic [ahb_sub_pkg::STRB_W-1:0] bus_strobe,
    output logic                        bus_wen,
    output logic                        bus_ren,
    output logic                        bus_is_burst,
    output logic [1:0]                  bus_burst_type,
    output logic [ahb_sub_pkg::BLEN_W-1:0] bus_burst_length
);
    import ahb_sub_pkg::*;

    // single request fields, zero unless enabled
    always_comb begin
        bus_addr = '0;
        bus_wdata = '0;
        bus_strobe = '0;
        bus_wen = 1'b0;
        bus_ren = 1'b0;
        if (req_en) begin
            bus_addr = dp.addr;
            // write data and strobe are live in the data phase
            bus_wdata = hwdata;
            bus_strobe = hwstrb;
            bus_wen = dp.write;
            bus_ren = !dp.write;
        end
    end

    // burst attributes
    always_comb begin
        bus_is_burst = 1'b0;
        bus_burst_type = '0;
        bus_burst_length = '0;
        if (burst_en && (dp.burst.raw != 3'b000)) begin
            bus_is_burst = 1'b1;
            // odd codes increment, even codes wrap
            bus_burst_type = dp.burst.f.incr ? BURST_TYPE_INCR : BURST_TYPE_WRAP;
            // 4/8/16 beats scale size, undefined-length incr gives 0
            if (dp.burst.f.len_code != 2'b00) begin
                bus_burst_length = BLEN_W'(dp.size) << (3'(dp.burst.f.len_code) + 3'd1);
            end
        end
    end

endmodule

// File: src/ahb_dphase_capture.sv
// address-phase capture for the ahb subordinate
// registers haddr/hwrite/htrans/hburst/hsize/hsel, holds them under stall,
// and checks the registered address against the window

`timescale 1ns/1ps

module ahb_dphase_capture (
    input  logic                        ahb_if,
    input  logic                        rst_n,
    input  logic                        hsel,
    input  logic [ahb_sub_pkg::ADDR_W-1:0] haddr,
    input  logic [1:0]                  htrans,
    input  logic                        hwrite,
    input  logic [2:0]                  hsize,
    input  ahb_sub_pkg::burst_u         hburst,
    input  logic                        bus_request_stall,
    ahb_dphase_if.capture               dp
);
    import ahb_sub_pkg::*;

    logic range_error;
    logic align_error;

    // control part of the address phase
    always_ff @(posedge ahb_if) begin
        if (!rst_n) begin
            dp.sel <= 1'b0;
            dp.trans <= HTRANS_IDLE;
        end else if (!bus_request_stall) begin
            dp.sel <= hsel;
            dp.trans <= htrans;
        end
    end

    // payload part, same enable
    always_ff @(posedge ahb_if) begin
        if (!bus_request_stall) begin
            dp.addr <= haddr;
            dp.write <= hwrite;
            dp.burst <= hburst;
            dp.size <= hsize;
        end
    end

    // window check on the registered address
    assign range_error = (dp.addr < BASE_ADDR) || (dp.addr >= TOP_ADDR);
    // word alignment only, hsize not considered
    assign align_error = (dp.addr & ADDR_W'(WORD_BYTES - 1)) != '0;

    assign dp.addr_error = dp.sel && (range_error || align_error);

endmodule

// File: src/ahb_dphase_if.sv
// data-phase attribute bundle
// carries the registered address phase and its address error

`timescale 1ns/1ps

interface ahb_dphase_if;
    import ahb_sub_pkg::*;

    // registered address-phase attributes
    logic [ADDR_W-1:0] addr;
    logic write;
    logic [1:0] trans;
    burst_u burst;
    logic [2:0] size;
    logic sel;
    // out of window or misaligned, qualified by sel
    logic addr_error;

    modport capture (
        output addr, write, trans, burst, size, sel, addr_error
    );

    modport user (
        input addr, write, trans, burst, size, sel, addr_error
    );

endinterface

// File: src/ahb_sub_ctrl.sv
// ahb subordinate control FSM
// idle/access/error sequencing, hreadyout/hresp/hrdata and request enables

`timescale 1ns/1ps

module ahb_sub_ctrl (
    input  logic                        ahb_if,
    input  logic                        rst_n,
    input  logic                        hsel,
    input  logic [1:0]                  htrans,
    ahb_dphase_if.user                  dp,
    input  logic                        bus_request_stall,
    input  logic                        bus_error,
    input  logic [ahb_sub_pkg::DATA_W-1:0] bus_rdata,
    output logic                        hreadyout,
    output logic                        hresp,
    output logic [ahb_sub_pkg::DATA_W-1:0] hrdata,
    output logic                        req_en,
    output logic                        burst_en
);
    import ahb_sub_pkg::*;

    logic [1:0] state;
    logic [1:0] next_state;
    // hreadyout from the previous cycle
    logic hreadyout_d;
    logic new_xfer;
    logic is_busy;
    logic err_hit;

    // selected non-idle transfer in the address phase
    assign new_xfer = hsel && (htrans != HTRANS_IDLE);
    assign is_busy = (dp.trans == HTRANS_BUSY);
    // addr error only once the previous beat completed
    assign err_hit = (dp.addr_error && hreadyout_d) || (bus_error && !is_busy);

    always_ff @(posedge ahb_if) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            hreadyout_d <= 1'b0;
        end else begin
            state <= next_state;
            hreadyout_d <= hreadyout;
        end
    end

    // next state
    always_comb begin
        next_state = ST_IDLE;
        case (state)
            ST_IDLE: begin
                if (new_xfer) begin
                    next_state = ST_ACCESS;
                end
            end
            ST_ACCESS: begin
                if (err_hit) begin
                    next_state = ST_ERROR;
                end else if (bus_request_stall || new_xfer) begin
                    // stalled beat or pipelined next transfer
                    next_state = ST_ACCESS;
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    // ahb response
    always_comb begin
        hreadyout = 1'b1;
        hresp = 1'b0;
        hrdata = '0;
        case (state)
            ST_ACCESS: begin
                hrdata = bus_rdata;
                if (err_hit) begin
                    // first error cycle
                    hreadyout = 1'b0;
                    hresp = 1'b1;
                end else if (!is_busy && bus_request_stall) begin
                    hreadyout = 1'b0;
                end
            end
            ST_ERROR: begin
                // second error cycle
                hrdata = bus_rdata;
                hresp = 1'b1;
            end
            default: begin
                hrdata = '0;
            end
        endcase
    end

    // request enables for the downstream side
    assign req_en = (state == ST_ACCESS) && !is_busy && !dp.addr_error;
    assign burst_en = (state == ST_ACCESS) && !dp.addr_error;

endmodule

// File: src/ahb_sub_pkg.sv
// ahb subordinate shared definitions
// widths, address window, transfer codes and the hburst union

package ahb_sub_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int WORD_BYTES = 4;

    // address window, top is first address outside
    localparam logic [ADDR_W-1:0] BASE_ADDR = 32'hF000_0000;
    localparam int NWORDS = 4;
    localparam logic [ADDR_W-1:0] TOP_ADDR = BASE_ADDR + NWORDS * WORD_BYTES;

    // htrans codes
    localparam logic [1:0] HTRANS_IDLE = 2'b00;
    localparam logic [1:0] HTRANS_BUSY = 2'b01;

    // downstream burst fields
    localparam int BLEN_W = 8;
    localparam logic [1:0] BURST_TYPE_INCR = 2'b10;
    localparam logic [1:0] BURST_TYPE_WRAP = 2'b11;

    // controller state codes
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ACCESS = 2'd1;
    localparam logic [1:0] ST_ERROR = 2'd2;

    // hburst seen as raw code or as length code plus incr bit
    typedef union packed {
        logic [2:0] raw;
        struct packed {
            logic [1:0] len_code;
            logic incr;
        } f;
    } burst_u;

endpackage

// File: src/ahb_subordinate.sv
// ahb-lite subordinate bridging to a stall/error memory bus
// top level, connects capture, control and request driver

`timescale 1ns/1ps

module ahb_subordinate (
    input  logic                        ahb_if,
    input  logic                        rst_n,
    // ahb-lite side
    input  logic                        hsel,
    input  logic [ahb_sub_pkg::ADDR_W-1:0] haddr,
    input  logic [1:0]                  htrans,
    input  logic                        hwrite,
    input  logic [2:0]                  hsize,
    input  logic [2:0]                  hburst,
    input  logic [ahb_sub_pkg::DATA_W-1:0] hwdata,
    input  logic [ahb_sub_pkg::STRB_W-1:0] hwstrb,
    output logic                        hreadyout,
    output logic                        hresp,
    output logic [ahb_sub_pkg::DATA_W-1:0] hrdata,
    // downstream bus side
    input  logic [ahb_sub_pkg::DATA_W-1:0] bus_rdata,
    input  logic                        bus_error,
    input  logic                        bus_request_stall,
    output logic [ahb_sub_pkg::ADDR_W-1:0] bus_addr,
    output logic [ahb_sub_pkg::DATA_W-1:0] bus_wdata,
    output logic [ahb_sub_pkg::STRB_W-1:0] bus_strobe,
    output logic                        bus_wen,
    output logic                        bus_ren,
    output logic                        bus_is_burst,
    output logic [1:0]                  bus_burst_type,
    output logic [ahb_sub_pkg::BLEN_W-1:0] bus_burst_length
);

    // ctrl to request driver
    logic req_en;
    logic burst_en;

    // registered address phase
    ahb_dphase_if dp_if ();

    ahb_dphase_capture ahb_dphase_capture_i (
        .ahb_if            (ahb_if),
        .rst_n             (rst_n),
        .hsel              (hsel),
        .haddr             (haddr),
        .htrans            (htrans),
        .hwrite            (hwrite),
        .hsize             (hsize),
        .hburst            (hburst),
        .bus_request_stall (bus_request_stall),
        .dp                (dp_if.capture)
    );

    ahb_sub_ctrl ahb_sub_ctrl_i (
        .ahb_if            (ahb_if),
        .rst_n             (rst_n),
        .hsel              (hsel),
        .htrans            (htrans),
        .dp                (dp_if.user),
        .bus_request_stall (bus_request_stall),
        .bus_error         (bus_error),
        .bus_rdata         (bus_rdata),
        .hreadyout         (hreadyout),
        .hresp             (hresp),
        .hrdata            (hrdata),
        .req_en            (req_en),
        .burst_en          (burst_en)
    );

    ahb_bus_request ahb_bus_request_i (
        .dp               (dp_if.user),
        .req_en           (req_en),
        .burst_en         (burst_en),
        .hwdata           (hwdata),
        .hwstrb           (hwstrb),
        .bus_addr         (bus_addr),
        .bus_wdata        (bus_wdata),
        .bus_strobe       (bus_strobe),
        .bus_wen          (bus_wen),
        .bus_ren          (bus_ren),
        .bus_is_burst     (bus_is_burst),
        .bus_burst_type   (bus_burst_type),
        .bus_burst_length (bus_burst_length)
    );

endmodule
